// File: logic/whiten_consts.svh
`ifndef WHITEN_CONSTS_SVH
`define WHITEN_CONSTS_SVH

// Width of one data word on the stream.
`define WHITEN_DATA_W 16

// Buffer depths.
`define WHITEN_IN_DEPTH  4  // Power of two.
`define WHITEN_OUT_DEPTH 6  // Not a power of two.

// APB register map, byte offsets.
`define WHITEN_ADDR_CTRL      5'h00  // Bit 0 requests a flush.
`define WHITEN_ADDR_SEED      5'h04
`define WHITEN_ADDR_DATA      5'h08  // Push with last low.
`define WHITEN_ADDR_DATA_LAST 5'h0C  // Push with last high.
`define WHITEN_ADDR_STATUS    5'h10  // Read only.

// Keystream seed after reset.
`define WHITEN_RESET_SEED 16'hACE1

`endif

// File: logic/whiten_pkg.sv
`default_nettype none

`include "whiten_consts.svh"

package whiten_pkg;

  // Word as written by the host.
  typedef logic [`WHITEN_DATA_W-1:0] raw_word_t;

  // Keystream generator state.
  typedef logic [15:0] lfsr_t;

  // Whitened word with its even parity bit.
  // Parity is the XOR of all data bits, so the
  // 17-bit word always has an even number of ones.
  typedef struct packed {
    logic [`WHITEN_DATA_W-1:0] data;
    logic                      parity;
  } enc_word_t;

endpackage

`default_nettype wire

// File: logic/word_if.sv
`default_nettype none

// Valid/ready word link with a last flag.
interface word_if #(
  parameter type T = logic
) ();

  logic valid;   // Source has a word.
  logic ready;   // Sink can take a word.
  T     payload;
  logic last;    // Final word of a packet.

  // Payload and last hold while valid waits for ready.
  modport src (
    output valid,
    output payload,
    output last,
    input  ready
  );

  modport dst (
    input  valid,
    input  payload,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// File: logic/stream_fifo.sv
`default_nettype none

module stream_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4      // Two or more.
) (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_flush,

  word_if.dst                        wr,
  word_if.src                        rd,

  output logic [$clog2(DEPTH+1)-1:0] o_count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam bit POW2  = ((DEPTH & (DEPTH - 1)) == 0);

  typedef struct packed {
    T     payload;
    logic last;
  } entry_t;

  entry_t mem [DEPTH];

  // Top bit of each pointer is the wrap flag.
  logic [PTR_W:0]   wptr_q;
  logic [PTR_W:0]   rptr_q;
  logic [PTR_W:0]   wptr_nxt;
  logic [PTR_W:0]   rptr_nxt;
  logic [CNT_W-1:0] count_q;

  logic do_push;
  logic do_pop;
  logic idx_equal;
  logic wrap_diff;
  logic full;
  logic empty;

  if (POW2) begin : g_pow2
    // Carry out of the index lands in the wrap bit.
    assign wptr_nxt = wptr_q + 1'b1;
    assign rptr_nxt = rptr_q + 1'b1;
  end else begin : g_npow2
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

    logic w_wrap;
    logic r_wrap;

    assign w_wrap = (wptr_q[PTR_W-1:0] == LAST_IDX);
    assign r_wrap = (rptr_q[PTR_W-1:0] == LAST_IDX);

    // Index returns to zero and the wrap bit toggles.
    assign wptr_nxt = w_wrap ? {~wptr_q[PTR_W], {PTR_W{1'b0}}} : wptr_q + 1'b1;
    assign rptr_nxt = r_wrap ? {~rptr_q[PTR_W], {PTR_W{1'b0}}} : rptr_q + 1'b1;
  end

  // Same index: empty if the wrap bits agree, full if not.
  assign idx_equal = (wptr_q[PTR_W-1:0] == rptr_q[PTR_W-1:0]);
  assign wrap_diff = (wptr_q[PTR_W] != rptr_q[PTR_W]);
  assign full      = idx_equal && wrap_diff;
  assign empty     = idx_equal && !wrap_diff;

  assign wr.ready = !full;   // Independent of the reader.
  assign rd.valid = !empty;

  assign do_push = wr.valid && wr.ready;
  assign do_pop  = rd.valid && rd.ready;

  assign rd.payload = mem[rptr_q[PTR_W-1:0]].payload;
  assign rd.last    = mem[rptr_q[PTR_W-1:0]].last;

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wptr_q[PTR_W-1:0]] <= '{payload: wr.payload, last: wr.last};
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (i_flush) begin
      wptr_q  <= '0;   // Drop everything held.
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= wptr_nxt;
      end
      if (do_pop) begin
        rptr_q <= rptr_nxt;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign o_count = count_q;

endmodule

`default_nettype wire

// File: logic/apb_regs.sv
`default_nettype none

`include "whiten_consts.svh"

module apb_regs (
  input  logic                                i_clk,
  input  logic                                i_rst_n,

  input  logic                                i_psel,
  input  logic                                i_penable,
  input  logic                                i_pwrite,
  input  logic [4:0]                          i_paddr,
  input  logic [31:0]                         i_pwdata,
  output logic [31:0]                         o_prdata,
  output logic                                o_pready,
  output logic                                o_pslverr,

  input  logic [$clog2(`WHITEN_IN_DEPTH+1)-1:0] i_in_count,
  input  logic                                i_out_valid,

  output logic                                o_flush,
  output whiten_pkg::lfsr_t                   o_seed,

  word_if.src                                 push
);

  whiten_pkg::lfsr_t seed_q;
  whiten_pkg::lfsr_t seed_wr;
  logic              flush_q;

  logic        access;
  logic        is_ctrl;
  logic        is_seed;
  logic        is_data;
  logic        is_data_last;
  logic        is_status;
  logic        mapped;
  logic        data_wr;
  logic        err;
  logic        done;
  logic [31:0] status;

  assign access = i_psel && i_penable;   // Access phase.

  assign is_ctrl      = (i_paddr == `WHITEN_ADDR_CTRL);
  assign is_seed      = (i_paddr == `WHITEN_ADDR_SEED);
  assign is_data      = (i_paddr == `WHITEN_ADDR_DATA);
  assign is_data_last = (i_paddr == `WHITEN_ADDR_DATA_LAST);
  assign is_status    = (i_paddr == `WHITEN_ADDR_STATUS);
  assign mapped       = is_ctrl || is_seed || is_data || is_data_last || is_status;

  assign data_wr = i_pwrite && (is_data || is_data_last);
  assign err     = !mapped || (i_pwrite && is_status);

  // Data writes wait for room in the ingress FIFO.
  assign o_pready  = access && (!data_wr || push.ready);
  assign o_pslverr = o_pready && err;
  assign done      = o_pready && !err;

  // Word is offered for the whole access phase.
  assign push.valid   = access && data_wr;
  assign push.payload = i_pwdata[`WHITEN_DATA_W-1:0];
  assign push.last    = is_data_last;

  // An all-zero state would lock the LFSR.
  assign seed_wr = (i_pwdata[15:0] == 16'h0000) ? 16'h0001 : i_pwdata[15:0];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      seed_q  <= `WHITEN_RESET_SEED;
      flush_q <= 1'b0;
    end else begin
      if (done && i_pwrite && is_seed) begin
        seed_q <= seed_wr;
      end
      // One-cycle pulse, also reloads the keystream.
      flush_q <= done && i_pwrite && ((is_ctrl && i_pwdata[0]) || is_seed);
    end
  end

  always_comb begin
    status             = '0;
    status[8]          = i_out_valid;
    status[$bits(i_in_count)-1:0] = i_in_count;
  end

  always_comb begin
    o_prdata = '0;
    if (is_seed) begin
      o_prdata[15:0] = seed_q;
    end else if (is_status) begin
      o_prdata = status;
    end
  end

  assign o_flush = flush_q;
  assign o_seed  = seed_q;

endmodule

`default_nettype wire

// File: logic/whiten_stage.sv
`default_nettype none

`include "whiten_consts.svh"

module whiten_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_flush,
  input  whiten_pkg::lfsr_t i_seed,

  word_if.dst               in,
  word_if.src               out
);

  whiten_pkg::lfsr_t     lfsr_q;
  whiten_pkg::enc_word_t enc_d;
  whiten_pkg::enc_word_t enc_q;
  logic                  last_q;
  logic                  valid_q;
  logic                  take;

  // Fibonacci step, taps 16, 14, 13, 11.
  function automatic whiten_pkg::lfsr_t lfsr_step(input whiten_pkg::lfsr_t s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Register is free when empty or being drained.
  assign in.ready = !valid_q || out.ready;
  assign take     = in.valid && in.ready;

  assign enc_d.data   = in.payload ^ lfsr_q;
  assign enc_d.parity = ^enc_d.data;   // Even parity.

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lfsr_q  <= `WHITEN_RESET_SEED;
      valid_q <= 1'b0;
    end else if (i_flush) begin
      lfsr_q  <= i_seed;
      valid_q <= 1'b0;   // Held word is discarded.
    end else if (take) begin
      lfsr_q  <= lfsr_step(lfsr_q);
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      enc_q  <= enc_d;
      last_q <= in.last;
    end
  end

  assign out.valid   = valid_q;
  assign out.payload = enc_q;
  assign out.last    = last_q;

endmodule

`default_nettype wire

// File: logic/whiten_top.sv
`default_nettype none

`include "whiten_consts.svh"

module whiten_top (
  input  logic                      i_clk,
  input  logic                      i_rst_n,

  input  logic                      i_psel,
  input  logic                      i_penable,
  input  logic                      i_pwrite,
  input  logic [4:0]                i_paddr,
  input  logic [31:0]               i_pwdata,
  output logic [31:0]               o_prdata,
  output logic                      o_pready,
  output logic                      o_pslverr,

  output logic                      o_tvalid,
  output logic [`WHITEN_DATA_W-1:0] o_tdata,
  output logic                      o_tparity,
  output logic                      o_tlast,
  input  logic                      i_tready
);

  word_if #(.T(whiten_pkg::raw_word_t)) in_raw  ();  // Host to ingress FIFO.
  word_if #(.T(whiten_pkg::raw_word_t)) mid_raw ();  // Ingress FIFO to stage.
  word_if #(.T(whiten_pkg::enc_word_t)) out_enc ();  // Stage to egress FIFO.
  word_if #(.T(whiten_pkg::enc_word_t)) tx_enc  ();  // Egress FIFO to ports.

  logic                                flush;
  whiten_pkg::lfsr_t                   seed;
  logic [$clog2(`WHITEN_IN_DEPTH+1)-1:0] in_count;

  apb_regs u_apb (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .i_in_count  (in_count),
    .i_out_valid (tx_enc.valid),
    .o_flush     (flush),
    .o_seed      (seed),
    .push        (in_raw)
  );

  stream_fifo #(
    .T     (whiten_pkg::raw_word_t),
    .DEPTH (`WHITEN_IN_DEPTH)
  ) u_in_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_flush (flush),
    .wr      (in_raw),
    .rd      (mid_raw),
    .o_count (in_count)
  );

  whiten_stage u_stage (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_flush (flush),
    .i_seed  (seed),
    .in      (mid_raw),
    .out     (out_enc)
  );

  stream_fifo #(
    .T     (whiten_pkg::enc_word_t),
    .DEPTH (`WHITEN_OUT_DEPTH)
  ) u_out_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_flush (flush),
    .wr      (out_enc),
    .rd      (tx_enc),
    .o_count ()        // Status only reports egress-not-empty.
  );

  assign o_tvalid     = tx_enc.valid;
  assign o_tdata      = tx_enc.payload.data;
  assign o_tparity    = tx_enc.payload.parity;
  assign o_tlast      = tx_enc.last;
  assign tx_enc.ready = i_tready;

endmodule

`default_nettype wire

// File: verif/whiten_assertions.sv
`default_nettype none

`include "whiten_consts.svh"

module whiten_assertions (
  input logic                      i_clk,
  input logic                      i_rst_n,
  input logic                      i_flush,
  input logic                      i_psel,
  input logic                      i_penable,
  input logic                      i_pwrite,
  input logic [4:0]                i_paddr,
  input logic                      i_pready,
  input logic                      i_pslverr,
  input logic                      i_tvalid,
  input logic                      i_tready,
  input logic [`WHITEN_DATA_W+1:0] i_tword,   // {data, parity, last}.
  input logic                      i_in_full,  // Full by the entry counter.
  input logic                      i_in_push,
  input logic                      i_out_full,
  input logic                      i_out_push
);

  logic data_wr;

  assign data_wr = i_psel && i_penable && i_pwrite &&
                   (i_paddr == `WHITEN_ADDR_DATA || i_paddr == `WHITEN_ADDR_DATA_LAST);

  // A flush may drop the held word.
  tx_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_tvalid && !i_tready && !i_flush |=> i_tvalid && $stable(i_tword))
    else $error("Output word changed while stalled");

  data_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    data_wr && i_in_full |-> !i_pready && !i_pslverr)
    else $error("Data write completed into a full ingress FIFO");

  in_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_in_full |-> !i_in_push)
    else $error("Ingress FIFO accepted a push while full");

  out_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_out_full |-> !i_out_push)
    else $error("Egress FIFO accepted a push while full");

endmodule

bind whiten_top whiten_assertions u_assertions (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_flush    (flush),
  .i_psel     (i_psel),
  .i_penable  (i_penable),
  .i_pwrite   (i_pwrite),
  .i_paddr    (i_paddr),
  .i_pready   (o_pready),
  .i_pslverr  (o_pslverr),
  .i_tvalid   (o_tvalid),
  .i_tready   (i_tready),
  .i_tword    ({o_tdata, o_tparity, o_tlast}),
  .i_in_full  (in_count == `WHITEN_IN_DEPTH),
  .i_in_push  (u_in_fifo.do_push),
  .i_out_full (u_out_fifo.o_count == `WHITEN_OUT_DEPTH),
  .i_out_push (u_out_fifo.do_push)
);

`default_nettype wire

// File: verif/whiten_tb.sv
`default_nettype none

`include "whiten_consts.svh"

module whiten_tb;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_psel;
  logic        i_penable;
  logic        i_pwrite;
  logic [4:0]  i_paddr;
  logic [31:0] i_pwdata;
  logic [31:0] o_prdata;
  logic        o_pready;
  logic        o_pslverr;
  logic        o_tvalid;
  logic [15:0] o_tdata;
  logic        o_tparity;
  logic        o_tlast;
  logic        i_tready;

  logic [17:0]       exp_q[$];     // {data, parity, last}.
  logic [17:0]       exp_word;
  whiten_pkg::lfsr_t key;          // Model keystream state.
  whiten_pkg::lfsr_t seed_reg;     // Model of the seed register.
  logic [31:0]       rdata;
  logic              err;
  int                tready_mode;  // 0 ready, 1 stalled, 2 random.
  int                seed_init;

  whiten_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(negedge i_clk) begin
    i_tready = (tready_mode == 0) || ((tready_mode == 2) && ($urandom_range(0, 1) == 1));
  end

  // One keystream step, taps at bits 15, 13, 12 and 10.
  function automatic whiten_pkg::lfsr_t next_key(input whiten_pkg::lfsr_t s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return (s << 1) | fb;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_with_error($sformatf("FAIL %s expected %h got %h", name, exp, got));
  endtask

  task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata);
    int waits;
    waits = 0;
    @(negedge i_clk);
    i_psel   = 1'b1;   // Setup phase.
    i_pwrite = wr;
    i_paddr  = addr;
    i_pwdata = wdata;
    @(negedge i_clk);
    i_penable = 1'b1;
    @(posedge i_clk);
    while (!o_pready) begin
      waits++;
      assert (waits < 100) else stop_with_error("APB transfer timed out waiting for o_pready");
      @(posedge i_clk);
    end
    rdata = o_prdata;
    err   = o_pslverr;
    @(negedge i_clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic send_word(input logic [15:0] data, input logic last);
    logic [15:0] enc;
    apb_xfer(1'b1, last ? `WHITEN_ADDR_DATA_LAST : `WHITEN_ADDR_DATA, {16'h0, data});
    check_value("o_pslverr", err, 1'b0);
    enc = data ^ key;
    exp_q.push_back({enc, ^enc, last});
    key = next_key(key);
  endtask

  task automatic send_burst(input int n);
    repeat (n) send_word($urandom, $urandom_range(0, 1));
  endtask

  // Seed writes and flushes restart the keystream and drop buffered words.
  task automatic reload(input logic [4:0] addr, input logic [31:0] wdata);
    apb_xfer(1'b1, addr, wdata);
    check_value("o_pslverr", err, 1'b0);
    if (addr == `WHITEN_ADDR_SEED) begin
      seed_reg = (wdata[15:0] == 16'h0) ? 16'h0001 : wdata[15:0];
    end
    key = seed_reg;
    exp_q.delete();
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      cycles++;
      assert (cycles < 2000) else stop_with_error("Timed out waiting for words at the output");
      @(negedge i_clk);
    end
  endtask

  always @(posedge i_clk) begin
    if (i_rst_n && o_tvalid && i_tready) begin
      assert (exp_q.size() != 0) else stop_with_error("Output word appeared with none expected");
      exp_word = exp_q.pop_front();
      check_value("o_tdata", o_tdata, exp_word[17:2]);
      check_value("o_tparity", o_tparity, exp_word[1]);
      check_value("o_tlast", o_tlast, exp_word[0]);
    end
  end

  initial begin
    seed_init   = $urandom(61781);
    i_rst_n     = 1'b0;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    i_tready    = 1'b1;
    tready_mode = 0;
    key         = `WHITEN_RESET_SEED;
    seed_reg    = `WHITEN_RESET_SEED;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    send_burst(20);   // Reset keystream, output always ready.
    wait_drain();

    tready_mode = 2;
    reload(`WHITEN_ADDR_SEED, 32'h5A3C);
    send_burst(15);
    wait_drain();
    reload(`WHITEN_ADDR_SEED, 32'h0);   // Zero seed becomes 0x0001.
    send_burst(15);
    wait_drain();

    // Fill ingress, stage and egress with the output stalled.
    tready_mode = 1;
    send_burst(11);
    apb_xfer(1'b0, `WHITEN_ADDR_STATUS, 32'h0);
    check_value("status in_count", rdata[2:0], 3'd4);
    check_value("status out_valid", rdata[8], 1'b1);
    fork
      send_word(16'hC0DE, 1'b1);
      begin
        repeat (8) begin
          @(posedge i_clk);
          check_value("o_pready", o_pready, 1'b0);
        end
        tready_mode = 0;
      end
    join
    wait_drain();

    tready_mode = 1;
    send_burst(5);
    reload(`WHITEN_ADDR_CTRL, 32'h1);
    @(negedge i_clk);   // Flush pulse has emptied the buffers.
    tready_mode = 0;
    repeat (10) @(negedge i_clk);   // Nothing may come out here.
    send_burst(6);
    wait_drain();

    apb_xfer(1'b0, 5'h14, 32'h0);
    check_value("o_pslverr", err, 1'b1);
    apb_xfer(1'b1, `WHITEN_ADDR_STATUS, 32'hFFFF);
    check_value("o_pslverr", err, 1'b1);
    apb_xfer(1'b1, 5'h1C, 32'h1234);
    check_value("o_pslverr", err, 1'b1);
    send_burst(4);
    wait_drain();
    reload(`WHITEN_ADDR_SEED, 32'hBEEF);
    apb_xfer(1'b0, `WHITEN_ADDR_SEED, 32'h0);
    check_value("o_prdata", rdata, 32'h0000BEEF);
    send_burst(4);
    wait_drain();

    if (exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_with_error("Expected words were left over at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/whiten_pkg.sv
logic/word_if.sv
logic/stream_fifo.sv
logic/apb_regs.sv
logic/whiten_stage.sv
logic/whiten_top.sv
verif/whiten_assertions.sv
verif/whiten_tb.sv

// File: Bender.yml
package:
  name: whiten

sources:
  - include_dirs:
      - logic
    files:
      - logic/whiten_pkg.sv
      - logic/word_if.sv
      - logic/stream_fifo.sv
      - logic/apb_regs.sv
      - logic/whiten_stage.sv
      - logic/whiten_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/whiten_assertions.sv
      - verif/whiten_tb.sv
